// File: verilog/trace_macros.svh
////////////////////////////////////////
// Sizes and register map of the trace unit
// Include in any file that needs them
////////////////////////////////////////
`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

`define TRACE_TAG_W    3       // Instruction tag width
`define TRACE_DEPTH    8       // Table entries above the 5 in flight
`define TRACE_STALL_W  8       // Saturating stall count width

// Register map on a 2-bit address
`define REG_CTRL       2'd0
`define REG_RETIRED    2'd1
`define REG_FLUSHED    2'd2
`define REG_CYCLE      2'd3

`endif

// File: verilog/trace_pkg.sv
////////////////////////////////////////
// Types shared by the pipeline trace unit
// Stage slots, per-cycle events, trace records
////////////////////////////////////////
`include "trace_macros.svh"

package trace_pkg;

    typedef enum logic [2:0] {
        STAGE_IF  = 3'd0,
        STAGE_ID  = 3'd1,
        STAGE_EX  = 3'd2,
        STAGE_MEM = 3'd3,
        STAGE_WB  = 3'd4
    } stage_e;

    typedef enum logic [1:0] {
        RA_CTRL    = `REG_CTRL,
        RA_RETIRED = `REG_RETIRED,
        RA_FLUSHED = `REG_FLUSHED,
        RA_CYCLE   = `REG_CYCLE
    } reg_addr_e;

    typedef struct packed {
        logic                    valid;
        logic [`TRACE_TAG_W-1:0] tag;
    } stage_slot_t;

    // What happens at the coming clock edge
    typedef struct packed {
        logic [4:0]        enter;      // Stage newly occupied
        stage_slot_t [4:0] slots;      // Occupants after the edge
        logic [31:0]       fetch_pc;
        logic              stall_hit;  // Decode occupant held
        logic              retire;     // Write-back occupant leaves
        logic [1:0]        flushed;    // Valid instructions killed
    } stage_events_t;

    typedef struct packed {
        logic [`TRACE_TAG_W-1:0]   tag;
        logic [31:0]               pc;
        logic [31:0]               cyc_if;
        logic [31:0]               cyc_id;
        logic [31:0]               cyc_ex;
        logic [31:0]               cyc_mem;
        logic [31:0]               cyc_wb;
        logic [`TRACE_STALL_W-1:0] stall_cycles;
    } trace_record_t;

endpackage

// File: verilog/pipe_tag_shifter.sv
////////////////////////////////////////
// Shadows the core's five stages with instruction tags
// Events describe the coming edge, so they are combinational
////////////////////////////////////////
`include "trace_macros.svh"

module pipe_tag_shifter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_valid,
    input  logic                     stall,
    input  logic                     flush,
    input  logic [31:0]              fetch_pc,
    output trace_pkg::stage_events_t events
);
    import trace_pkg::*;

    stage_slot_t [4:0]       slots_q;     // Current occupants
    stage_slot_t [4:0]       slots_d;
    logic [`TRACE_TAG_W-1:0] next_tag_q;  // Wrapping tag source
    logic                    advance;     // Fetch and decode move on
    logic                    fetch_take;  // Accepted fetch
    logic                    dup_tag;

    assign advance    = !stall && !flush;
    assign fetch_take = fetch_valid && advance;

    ////////////////////////////////////////
    // Stage rules where flush wins over stall
    ////////////////////////////////////////
    always_comb begin
        slots_d[STAGE_WB]  = slots_q[STAGE_MEM];
        slots_d[STAGE_MEM] = slots_q[STAGE_EX];
        slots_d[STAGE_EX]  = advance ? slots_q[STAGE_ID] : '0;  // Bubble on hold
        if (flush) begin
            slots_d[STAGE_ID] = '0;
            slots_d[STAGE_IF] = '0;
        end else if (stall) begin
            slots_d[STAGE_ID] = slots_q[STAGE_ID];
            slots_d[STAGE_IF] = slots_q[STAGE_IF];
        end else begin
            slots_d[STAGE_ID] = slots_q[STAGE_IF];
            slots_d[STAGE_IF] = '{valid: fetch_valid, tag: next_tag_q};
        end
    end

    always_comb begin
        events.enter[STAGE_IF]  = fetch_take;
        events.enter[STAGE_ID]  = advance && slots_q[STAGE_IF].valid;
        events.enter[STAGE_EX]  = advance && slots_q[STAGE_ID].valid;
        events.enter[STAGE_MEM] = slots_q[STAGE_EX].valid;
        events.enter[STAGE_WB]  = slots_q[STAGE_MEM].valid;
        events.slots            = slots_d;
        events.fetch_pc         = fetch_pc;
        events.stall_hit        = stall && !flush && slots_q[STAGE_ID].valid;
        events.retire           = slots_q[STAGE_WB].valid;
        events.flushed          = flush ? {1'b0, slots_q[STAGE_IF].valid} +
                                          {1'b0, slots_q[STAGE_ID].valid} : 2'd0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slots_q    <= '0;
            next_tag_q <= '0;
        end else begin
            slots_q <= slots_d;
            if (fetch_take) begin
                next_tag_q <= next_tag_q + 1'b1;
            end
        end
    end

    // Tags in flight must be distinct or the table aliases them
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < 5; i++) begin
            for (int j = i + 1; j < 5; j++) begin
                if (slots_q[i].valid && slots_q[j].valid && slots_q[i].tag == slots_q[j].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    a_unique_tags: assert property (@(posedge clk) disable iff (rst) !dup_tag);

endmodule

// File: verilog/trace_record_table.sv
////////////////////////////////////////
// Per-tag table of stage timestamps and stall counts
// Emits a full record when its instruction retires
////////////////////////////////////////
`include "trace_macros.svh"

module trace_record_table (
    input  logic                     clk,
    input  logic                     rst,
    input  trace_pkg::stage_events_t events,
    input  logic                     trace_en,
    input  logic [31:0]              cycle,
    output trace_pkg::trace_record_t record,
    output logic                     record_valid
);
    import trace_pkg::*;

    trace_record_t           table_q [`TRACE_DEPTH];
    logic [`TRACE_TAG_W-1:0] wb_tag_q;   // Tag held in write-back now
    logic [31:0]             stamp;      // Counter value after the edge
    logic                    if_hold;    // Fetch occupant held by stall
    stage_slot_t             slot_if;
    stage_slot_t             slot_id;

    function automatic logic [`TRACE_STALL_W-1:0] sat_inc(
        input logic [`TRACE_STALL_W-1:0] v
    );
        return (v == '1) ? v : v + 1'b1;
    endfunction

    assign stamp   = cycle + 32'd1;
    assign slot_if = events.slots[STAGE_IF];
    assign slot_id = events.slots[STAGE_ID];
    // A valid fetch occupant that did not just enter is held and counts too
    // so latency stays 4 plus stall_cycles
    assign if_hold = slot_if.valid && !events.enter[STAGE_IF];

    ////////////////////////////////////////
    // Table writes
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (events.enter[STAGE_IF]) begin
            table_q[slot_if.tag] <= '{tag: slot_if.tag, pc: events.fetch_pc,
                                      cyc_if: stamp, default: '0};
        end
        if (events.enter[STAGE_ID]) begin
            table_q[slot_id.tag].cyc_id <= stamp;
        end
        if (events.enter[STAGE_EX]) begin
            table_q[events.slots[STAGE_EX].tag].cyc_ex <= stamp;
        end
        if (events.enter[STAGE_MEM]) begin
            table_q[events.slots[STAGE_MEM].tag].cyc_mem <= stamp;
        end
        if (events.enter[STAGE_WB]) begin
            table_q[events.slots[STAGE_WB].tag].cyc_wb <= stamp;
        end
        if (events.stall_hit) begin  // Held occupant keeps its tag
            table_q[slot_id.tag].stall_cycles <= sat_inc(table_q[slot_id.tag].stall_cycles);
        end
        if (if_hold) begin
            table_q[slot_if.tag].stall_cycles <= sat_inc(table_q[slot_if.tag].stall_cycles);
        end
    end

    ////////////////////////////////////////
    // Retire output
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        wb_tag_q <= events.slots[STAGE_WB].tag;
        if (events.retire) begin
            record <= table_q[wb_tag_q];  // Write-back stamp already stored
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            record_valid <= 1'b0;
        end else begin
            record_valid <= events.retire && trace_en;
        end
    end

    a_stamps_ordered: assert property (@(posedge clk) disable iff (rst)
        record_valid |-> (record.cyc_if <= record.cyc_id) &&
                         (record.cyc_id <= record.cyc_ex) &&
                         (record.cyc_ex <= record.cyc_mem) &&
                         (record.cyc_mem <= record.cyc_wb));

endmodule

// File: verilog/trace_ctrl_regs.sv
////////////////////////////////////////
// Trace enable and read-only statistics counters
// Plain write strobe, combinational read
////////////////////////////////////////

module trace_ctrl_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     reg_wr,
    input  logic [1:0]               reg_addr,
    input  logic [31:0]              reg_wdata,
    output logic [31:0]              reg_rdata,
    input  trace_pkg::stage_events_t events,
    output logic                     trace_en,
    output logic [31:0]              cycle
);
    import trace_pkg::*;

    reg_addr_e   addr;
    logic [31:0] retired_q;  // Retirements while enabled
    logic [31:0] flushed_q;  // Instructions killed by flush

    assign addr = reg_addr_e'(reg_addr);

    ////////////////////////////////////////
    // Registers and counters
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trace_en  <= 1'b1;
            cycle     <= '0;
            retired_q <= '0;
            flushed_q <= '0;
        end else begin
            cycle <= cycle + 32'd1;  // Free running
            if (reg_wr && addr == RA_CTRL) begin
                trace_en <= reg_wdata[0];
            end
            if (reg_wr && addr == RA_RETIRED) begin
                retired_q <= '0;
            end else if (events.retire && trace_en) begin
                retired_q <= retired_q + 32'd1;
            end
            if (reg_wr && addr == RA_FLUSHED) begin
                flushed_q <= '0;
            end else begin
                flushed_q <= flushed_q + {30'd0, events.flushed};
            end
        end
    end

    always_comb begin
        case (addr)
            RA_CTRL:    reg_rdata = {31'd0, trace_en};
            RA_RETIRED: reg_rdata = retired_q;
            RA_FLUSHED: reg_rdata = flushed_q;
            RA_CYCLE:   reg_rdata = cycle;
            default:    reg_rdata = '0;
        endcase
    end

endmodule

// File: verilog/pipe_trace_top.sv
////////////////////////////////////////
// Pipeline trace unit top level
// Tag shifter, record table and register block
////////////////////////////////////////

module pipe_trace_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_valid,
    input  logic [31:0]              fetch_pc,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     reg_wr,
    input  logic [1:0]               reg_addr,
    input  logic [31:0]              reg_wdata,
    output logic [31:0]              reg_rdata,
    output trace_pkg::trace_record_t record,
    output logic                     record_valid
);
    import trace_pkg::*;

    stage_events_t events;    // Shifter to table and registers
    logic          trace_en;
    logic [31:0]   cycle;

    pipe_tag_shifter i_pipe_tag_shifter (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .fetch_pc    (fetch_pc),
        .events      (events)
    );

    trace_record_table i_trace_record_table (
        .clk          (clk),
        .rst          (rst),
        .events       (events),
        .trace_en     (trace_en),
        .cycle        (cycle),
        .record       (record),
        .record_valid (record_valid)
    );

    trace_ctrl_regs i_trace_ctrl_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .events    (events),
        .trace_en  (trace_en),
        .cycle     (cycle)
    );

endmodule

// File: verif/tb_pipe_trace.sv
////////////////////////////////////////
// Testbench for the pipeline trace unit
// Plays the core with random fetch, stall and flush
// and checks records against a cycle model of the stages
////////////////////////////////////////
`include "trace_macros.svh"

module tb_pipe_trace;
    timeunit 1ns;
    timeprecision 1ps;
    import trace_pkg::*;

    logic          clk = 1'b0;
    logic          rst;
    logic          fetch_valid;
    logic [31:0]   fetch_pc;
    logic          stall;
    logic          flush;
    logic          reg_wr;
    logic [1:0]    reg_addr;
    logic [31:0]   reg_wdata;
    logic [31:0]   reg_rdata;
    trace_record_t record;
    logic          record_valid;

    ////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////
    stage_slot_t             m_slot [5] = '{default: '0};
    trace_record_t           m_tab [`TRACE_DEPTH];
    trace_record_t           exp_q [$];        // Expected records in retire order
    logic [`TRACE_TAG_W-1:0] m_tag = '0;
    logic [31:0]             m_cycle = '0;
    logic [31:0]             m_retired = '0;   // Retires while enabled
    logic [31:0]             m_killed = '0;    // Flushed instructions
    logic                    m_en = 1'b1;
    logic                    exp_valid;
    int                      seen_records = 0;
    logic [31:0]             hold;

    pipe_trace_top i_pipe_trace_top (.*);

    always #5 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            fail_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    endtask

    // One clock edge of the stage rules on the model
    task automatic model_edge();
        stage_slot_t nxt [5];
        stage_slot_t fresh;
        logic        adv;
        logic [31:0] c_next;
        adv       = !stall && !flush;
        c_next    = m_cycle + 32'd1;
        fresh     = '{valid: fetch_valid, tag: m_tag};
        exp_valid = m_slot[STAGE_WB].valid && m_en;
        if (exp_valid) begin
            exp_q.push_back(m_tab[m_slot[STAGE_WB].tag]);
            m_retired = m_retired + 32'd1;
        end
        if (flush) begin
            m_killed = m_killed + 32'(m_slot[STAGE_IF].valid) + 32'(m_slot[STAGE_ID].valid);
        end
        for (int s = 0; s < 2; s++) begin
            if (stall && !flush && m_slot[s].valid &&
                m_tab[m_slot[s].tag].stall_cycles != '1) begin  // Held in fetch or decode
                m_tab[m_slot[s].tag].stall_cycles++;
            end
        end
        nxt[STAGE_WB]  = m_slot[STAGE_MEM];
        nxt[STAGE_MEM] = m_slot[STAGE_EX];
        nxt[STAGE_EX]  = adv ? m_slot[STAGE_ID] : '0;
        if (flush) begin
            nxt[STAGE_ID] = '0;
            nxt[STAGE_IF] = '0;
        end else if (stall) begin
            nxt[STAGE_ID] = m_slot[STAGE_ID];
            nxt[STAGE_IF] = m_slot[STAGE_IF];
        end else begin
            nxt[STAGE_ID] = m_slot[STAGE_IF];
            nxt[STAGE_IF] = fresh;
        end
        if (adv && nxt[STAGE_ID].valid)
            m_tab[nxt[STAGE_ID].tag].cyc_id = c_next;
        if (nxt[STAGE_EX].valid)
            m_tab[nxt[STAGE_EX].tag].cyc_ex = c_next;
        if (nxt[STAGE_MEM].valid)
            m_tab[nxt[STAGE_MEM].tag].cyc_mem = c_next;
        if (nxt[STAGE_WB].valid)
            m_tab[nxt[STAGE_WB].tag].cyc_wb = c_next;
        if (adv && fetch_valid) begin     // Accepted fetch opens a fresh entry
            m_tab[m_tag]        = '0;
            m_tab[m_tag].tag    = m_tag;
            m_tab[m_tag].pc     = fetch_pc;
            m_tab[m_tag].cyc_if = c_next;
            m_tag               = m_tag + 1'b1;
        end
        if (reg_wr && reg_addr == `REG_CTRL)
            m_en = reg_wdata[0];
        if (reg_wr && reg_addr == `REG_RETIRED)
            m_retired = '0;               // Write wins over a retire
        m_cycle = c_next;
        m_slot  = nxt;
    endtask

    // Edge, model update, output check, then the next stimulus
    task automatic cycle_step(input logic active);
        trace_record_t e;
        @(posedge clk);
        model_edge();
        #1;
        check_val("record_valid", 32'(exp_valid), 32'(record_valid));
        if (record_valid) begin
            e = exp_q.pop_front();
            check_val("record.tag", 32'(e.tag), 32'(record.tag));
            check_val("record.pc", e.pc, record.pc);
            check_val("record.cyc_if", e.cyc_if, record.cyc_if);
            check_val("record.cyc_id", e.cyc_id, record.cyc_id);
            check_val("record.cyc_ex", e.cyc_ex, record.cyc_ex);
            check_val("record.cyc_mem", e.cyc_mem, record.cyc_mem);
            check_val("record.cyc_wb", e.cyc_wb, record.cyc_wb);
            check_val("record.stall_cycles", 32'(e.stall_cycles), 32'(record.stall_cycles));
            check_val("latency", 32'd4 + 32'(e.stall_cycles),
                      record.cyc_wb - record.cyc_if);
            seen_records++;
        end
        reg_wr      = 1'b0;
        fetch_valid = active && ($urandom % 4 != 0);   // 3 in 4
        fetch_pc    = $urandom;
        stall       = active && ($urandom % 8 == 0);    // 1 in 8
        flush       = active && ($urandom % 16 == 0);   // 1 in 16
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        cycle_step(1'b1);
    endtask

    task automatic expect_reg(input string name, input logic [1:0] addr, input logic [31:0] exp);
        reg_addr = addr;
        #1;                               // Combinational read settles
        check_val(name, exp, reg_rdata);
    endtask

    function automatic logic pipe_busy();
        logic busy;
        busy = exp_q.size() != 0;
        for (int s = 0; s < 5; s++)
            busy = busy || m_slot[s].valid;
        return busy;
    endfunction

    // Until a record appears, or with drain set until the model is empty
    task automatic wait_for(input logic drain, input int limit);
        int waited;
        waited = 0;
        while (drain ? pipe_busy() : seen_records == 0) begin
            if (waited == limit && drain) begin
                fail_run("Timeout: the pipeline did not drain");
            end else if (waited == limit) begin
                fail_run("Timeout: no record after the trace was enabled again");
            end else begin
                cycle_step(!drain);
                waited++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'hfebe));
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        reg_wr      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Random traffic, every record checked as it retires
        for (int i = 0; i < 2000; i++)
            cycle_step(1'b1);
        expect_reg("cycle_count", `REG_CYCLE, m_cycle);
        expect_reg("retired_count", `REG_RETIRED, m_retired);
        write_reg(`REG_RETIRED, 32'd0);
        expect_reg("retired_clear", `REG_RETIRED, 32'd0);

        // Trace disabled for a window
        write_reg(`REG_CTRL, 32'd0);
        hold = m_retired;
        for (int i = 0; i < 200; i++)
            cycle_step(1'b1);
        expect_reg("retired_hold", `REG_RETIRED, hold);

        write_reg(`REG_CTRL, 32'd1);
        seen_records = 0;
        wait_for(1'b0, 100);
        for (int i = 0; i < 300; i++)
            cycle_step(1'b1);
        wait_for(1'b1, 50);
        expect_reg("flushed_count", `REG_FLUSHED, m_killed);
        expect_reg("retired_count", `REG_RETIRED, m_retired);
        expect_reg("cycle_count", `REG_CYCLE, m_cycle);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/trace_pkg.sv
verilog/pipe_tag_shifter.sv
verilog/trace_record_table.sv
verilog/trace_ctrl_regs.sv
verilog/pipe_trace_top.sv
verif/tb_pipe_trace.sv

// File: Makefile
# Verilator flow for the pipeline trace unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_pipe_trace -Mdir obj_dir -o sim_pipe_trace -f flist.f

run: compile
	./obj_dir/sim_pipe_trace

clean:
	rm -rf obj_dir
